// ==== rtl/wfd_mem_cfg_pkg.sv ====
`default_nettype none

package wfd_mem_cfg_pkg;

	////////////////////////////////////////
	// Sample path and memory sizes
	////////////////////////////////////////

	// Stream sample and bus word widths
	localparam int SAMPLE_W = 64;
	localparam int WORD_W = 32;

	// Sample memory, 32-bit words, two per beat
	localparam int MEM_WORDS = 2048;
	localparam int MEM_AW = 11;
	localparam int BEAT_AW = 10;

	// Beat FIFO, credits track free slots
	localparam int FIFO_DEPTH = 16;
	localparam int CREDIT_W = 5;

	// Overflow counter saturates at all ones
	localparam int OVF_W = 16;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [MEM_AW-1:0] mem_addr_t;
	typedef logic [BEAT_AW-1:0] beat_ptr_t;
	typedef logic [CREDIT_W-1:0] credit_t;
	typedef logic [OVF_W-1:0] ovf_cnt_t;
	// Register index on the control port
	typedef logic [1:0] wb_reg_addr_t;

endpackage

`default_nettype wire

// ==== rtl/wfd_mem_bus_pkg.sv ====
`default_nettype none

package wfd_mem_bus_pkg;

	////////////////////////////////////////
	// Sample beat
	////////////////////////////////////////

	// Producer to FIFO to writer
	typedef struct packed {
		wfd_mem_cfg_pkg::sample_t sample;
	} beat_t;

	////////////////////////////////////////
	// Wishbone
	////////////////////////////////////////

	// Master side, 29-bit word address
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [28:0] addr;
		wfd_mem_cfg_pkg::word_t dat;
	} wb_req_t;

	// Slave side
	typedef struct packed {
		logic ack;
		logic stall;
		wfd_mem_cfg_pkg::word_t dat;
	} wb_rsp_t;

	////////////////////////////////////////
	// Capture control and status
	////////////////////////////////////////

	// Clear is a single-cycle pulse
	typedef struct packed {
		logic enable;
		logic clear;
	} capture_ctrl_t;

	// Zero-padded to 32 bits, beats_written in the low bits
	typedef struct packed {
		logic enable;
		logic overflow_seen;
		wfd_mem_cfg_pkg::credit_t fifo_level;
		wfd_mem_cfg_pkg::beat_ptr_t beats_written;
	} capture_status_t;

	// Writer stores low word first
	typedef enum logic {
		LOW_WORD,
		HIGH_WORD
	} writer_state_t;

	// Register map
	localparam wfd_mem_cfg_pkg::wb_reg_addr_t REG_CTRL = 2'd0;
	localparam wfd_mem_cfg_pkg::wb_reg_addr_t REG_WPTR = 2'd1;
	localparam wfd_mem_cfg_pkg::wb_reg_addr_t REG_OVF = 2'd2;
	localparam wfd_mem_cfg_pkg::wb_reg_addr_t REG_STATUS = 2'd3;

endpackage

`default_nettype wire

// ==== rtl/gtp_stream_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module gtp_stream_packer (
	input wire wb_clk,
	input wire rst_i,
	input wire wfd_mem_cfg_pkg::sample_t gtp_dat_i,
	input wire gtp_vld_i,
	input wire wfd_mem_bus_pkg::capture_ctrl_t ctrl_i,
	input wire credit_return_i,
	output logic push_o,
	output wfd_mem_bus_pkg::beat_t beat_o,
	output wfd_mem_cfg_pkg::ovf_cnt_t ovf_cnt_o,
	output logic ovf_seen_o
);
	import wfd_mem_cfg_pkg::*;
	import wfd_mem_bus_pkg::*;

	// Free FIFO slots as seen from here
	credit_t credit;
	logic accept;
	logic drop;

	// Stream cannot stall, so no credit means the sample is lost
	assign accept = gtp_vld_i && ctrl_i.enable && (credit != '0);
	assign drop = gtp_vld_i && ctrl_i.enable && (credit == '0);

	////////////////////////////////////////
	// Beat register
	////////////////////////////////////////

	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			push_o <= 1'b0;
		end else begin
			push_o <= accept;
		end
	end

	// Payload only
	always_ff @(posedge wb_clk) begin
		if (accept) begin
			beat_o.sample <= gtp_dat_i;
		end
	end

	////////////////////////////////////////
	// Credits
	////////////////////////////////////////

	// Spent on accept, returned on each FIFO pop
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			credit <= credit_t'(FIFO_DEPTH);
		end else begin
			case ({credit_return_i, accept})
				2'b10: credit <= credit + 1'b1;
				2'b01: credit <= credit - 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	////////////////////////////////////////
	// Overflow accounting
	////////////////////////////////////////

	// Saturating count and sticky flag, clear wins
	always_ff @(posedge wb_clk) begin
		if (rst_i || ctrl_i.clear) begin
			ovf_cnt_o <= '0;
			ovf_seen_o <= 1'b0;
		end else if (drop) begin
			if (ovf_cnt_o != '1) begin
				ovf_cnt_o <= ovf_cnt_o + 1'b1;
			end
			ovf_seen_o <= 1'b1;
		end
	end

	// FIFO must hand back no more credits than it was given
	a_credit_bound: assert property (@(posedge wb_clk) disable iff (rst_i)
		credit <= credit_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== rtl/beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_fifo (
	input wire wb_clk,
	input wire rst_i,
	input wire push_i,
	input wire wfd_mem_bus_pkg::beat_t beat_i,
	input wire pop_i,
	output wfd_mem_bus_pkg::beat_t head_o,
	output logic not_empty_o,
	output wfd_mem_cfg_pkg::credit_t level_o,
	output logic credit_return_o
);
	import wfd_mem_cfg_pkg::*;
	import wfd_mem_bus_pkg::*;

	// Storage, no reset
	beat_t mem [FIFO_DEPTH];

	// Pointers wrap on their own at FIFO_DEPTH
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic do_pop;

	// A pop on an empty FIFO is ignored
	assign do_pop = pop_i && not_empty_o;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	always_ff @(posedge wb_clk) begin
		if (push_i) begin
			mem[wr_ptr] <= beat_i;
		end
	end

	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
		end else if (push_i) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// First-word fall-through
	assign head_o = mem[rd_ptr];
	assign not_empty_o = (level_o != '0);

	// One credit back per beat taken
	assign credit_return_o = do_pop;

	////////////////////////////////////////
	// Fill level
	////////////////////////////////////////

	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			level_o <= '0;
		end else begin
			case ({push_i, do_pop})
				2'b10: level_o <= level_o + 1'b1;
				2'b01: level_o <= level_o - 1'b1;
				default: level_o <= level_o;
			endcase
		end
	end

	// Credit scheme in the producer keeps these true
	a_no_push_full: assert property (@(posedge wb_clk) disable iff (rst_i)
		push_i |-> level_o != credit_t'(FIFO_DEPTH));
	a_no_pop_empty: assert property (@(posedge wb_clk) disable iff (rst_i)
		pop_i |-> level_o != '0);

endmodule

`default_nettype wire

// ==== rtl/sample_mem_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_mem_writer (
	input wire wb_clk,
	input wire rst_i,
	input wire wfd_mem_bus_pkg::capture_ctrl_t ctrl_i,
	input wire wfd_mem_bus_pkg::beat_t head_i,
	input wire not_empty_i,
	input wire wfd_mem_bus_pkg::wb_req_t wbm_req_i,
	output logic pop_o,
	output wfd_mem_bus_pkg::wb_rsp_t wbm_rsp_o,
	output wfd_mem_cfg_pkg::beat_ptr_t wptr_o
);
	import wfd_mem_cfg_pkg::*;
	import wfd_mem_bus_pkg::*;

	// Sample memory, two 32-bit words per beat
	word_t mem [MEM_WORDS];

	writer_state_t state;
	beat_ptr_t wptr;

	// Write port
	logic mem_we;
	mem_addr_t mem_waddr;
	word_t mem_wdat;

	// Read port
	logic rd_ack;
	word_t rd_dat;

	////////////////////////////////////////
	// Beat writer FSM
	////////////////////////////////////////

	// Low word waits for a beat, high word always follows
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			state <= LOW_WORD;
		end else begin
			case (state)
				LOW_WORD: begin
					if (not_empty_i) begin
						state <= HIGH_WORD;
					end
				end
				HIGH_WORD: state <= LOW_WORD;
				default: state <= LOW_WORD;
			endcase
		end
	end

	// Head leaves the FIFO with its high word
	assign pop_o = (state == HIGH_WORD);

	assign mem_we = (state == HIGH_WORD) || not_empty_i;
	// Word address 2p or 2p+1
	assign mem_waddr = {wptr, state == HIGH_WORD};
	assign mem_wdat = (state == HIGH_WORD) ? head_i.sample[SAMPLE_W-1:WORD_W]
		: head_i.sample[WORD_W-1:0];

	always_ff @(posedge wb_clk) begin
		if (mem_we) begin
			mem[mem_waddr] <= mem_wdat;
		end
	end

	// Beat pointer, wraps at 1024 beats
	always_ff @(posedge wb_clk) begin
		if (rst_i || ctrl_i.clear) begin
			wptr <= '0;
		end else if (pop_o) begin
			wptr <= wptr + 1'b1;
		end
	end

	assign wptr_o = wptr;

	////////////////////////////////////////
	// Wishbone read port
	////////////////////////////////////////

	// Every request acked next cycle, writes are dropped
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			rd_ack <= 1'b0;
		end else begin
			rd_ack <= wbm_req_i.cyc && wbm_req_i.stb;
		end
	end

	// Upper address bits alias
	always_ff @(posedge wb_clk) begin
		if (wbm_req_i.cyc && wbm_req_i.stb && !wbm_req_i.we) begin
			rd_dat <= mem[wbm_req_i.addr[MEM_AW-1:0]];
		end
	end

	assign wbm_rsp_o.ack = rd_ack;
	assign wbm_rsp_o.stall = 1'b0;
	assign wbm_rsp_o.dat = rd_dat;

	// Both words of a beat come from the same FIFO head
	a_head_stable: assert property (@(posedge wb_clk) disable iff (rst_i)
		state == LOW_WORD && not_empty_i |=> $stable(head_i));

endmodule

`default_nettype wire

// ==== rtl/wb_capture_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_capture_csr (
	input wire wb_clk,
	input wire rst_i,
	input wire wfd_mem_bus_pkg::wb_req_t wbr_req_i,
	input wire wfd_mem_cfg_pkg::beat_ptr_t wptr_i,
	input wire wfd_mem_cfg_pkg::ovf_cnt_t ovf_cnt_i,
	input wire ovf_seen_i,
	input wire wfd_mem_cfg_pkg::credit_t level_i,
	output wfd_mem_bus_pkg::wb_rsp_t wbr_rsp_o,
	output wfd_mem_bus_pkg::capture_ctrl_t ctrl_o,
	output wfd_mem_cfg_pkg::word_t status_o
);
	import wfd_mem_cfg_pkg::*;
	import wfd_mem_bus_pkg::*;

	logic req;
	logic ctrl_wr;
	wb_reg_addr_t idx;
	capture_status_t status;

	// Register pulses
	logic ack;
	logic enable;
	logic clear;
	word_t rd_dat;

	assign req = wbr_req_i.cyc && wbr_req_i.stb;
	assign idx = wb_reg_addr_t'(wbr_req_i.addr[1:0]);
	assign ctrl_wr = req && wbr_req_i.we && (idx == REG_CTRL);

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	// Enable in bit 0, bit 1 fires clear
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			ack <= 1'b0;
			enable <= 1'b0;
			clear <= 1'b0;
		end else begin
			ack <= req;
			clear <= ctrl_wr && wbr_req_i.dat[1];
			if (ctrl_wr) begin
				enable <= wbr_req_i.dat[0];
			end
		end
	end

	assign ctrl_o.enable = enable;
	assign ctrl_o.clear = clear;

	////////////////////////////////////////
	// Status and readback
	////////////////////////////////////////

	assign status.enable = enable;
	assign status.overflow_seen = ovf_seen_i;
	assign status.fifo_level = level_i;
	assign status.beats_written = wptr_i;
	assign status_o = {{(WORD_W - $bits(capture_status_t)){1'b0}}, status};

	// Read data sampled with the request
	always_ff @(posedge wb_clk) begin
		if (req) begin
			case (idx)
				REG_CTRL: rd_dat <= {{(WORD_W - 1){1'b0}}, enable};
				REG_WPTR: rd_dat <= {{(WORD_W - BEAT_AW){1'b0}}, wptr_i};
				REG_OVF: rd_dat <= {{(WORD_W - OVF_W){1'b0}}, ovf_cnt_i};
				default: rd_dat <= status_o;
			endcase
		end
	end

	assign wbr_rsp_o.ack = ack;
	assign wbr_rsp_o.stall = 1'b0;
	assign wbr_rsp_o.dat = rd_dat;

endmodule

`default_nettype wire

// ==== rtl/wfd_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module wfd_memory (
	input wire wb_clk,
	input wire rst_i,
	input wire wfd_mem_bus_pkg::wb_req_t wbm_req_i,
	input wire wfd_mem_bus_pkg::wb_req_t wbr_req_i,
	input wire wfd_mem_cfg_pkg::sample_t gtp_dat_i,
	input wire gtp_vld_i,
	output wfd_mem_bus_pkg::wb_rsp_t wbm_rsp_o,
	output wfd_mem_bus_pkg::wb_rsp_t wbr_rsp_o,
	output wfd_mem_cfg_pkg::word_t status_o
);
	import wfd_mem_cfg_pkg::*;
	import wfd_mem_bus_pkg::*;

	// Capture control from CSR
	capture_ctrl_t ctrl;

	// Producer to FIFO
	logic push;
	beat_t beat;
	logic credit_return;

	// FIFO to writer
	beat_t head;
	logic not_empty;
	logic pop;

	// Status back to CSR
	credit_t level;
	beat_ptr_t wptr;
	ovf_cnt_t ovf_cnt;
	logic ovf_seen;

	////////////////////////////////////////
	// Sample path
	////////////////////////////////////////

	gtp_stream_packer i_packer (
		.wb_clk (wb_clk),
		.rst_i (rst_i),
		.gtp_dat_i (gtp_dat_i),
		.gtp_vld_i (gtp_vld_i),
		.ctrl_i (ctrl),
		.credit_return_i (credit_return),
		.push_o (push),
		.beat_o (beat),
		.ovf_cnt_o (ovf_cnt),
		.ovf_seen_o (ovf_seen)
	);

	beat_fifo i_fifo (
		.wb_clk (wb_clk),
		.rst_i (rst_i),
		.push_i (push),
		.beat_i (beat),
		.pop_i (pop),
		.head_o (head),
		.not_empty_o (not_empty),
		.level_o (level),
		.credit_return_o (credit_return)
	);

	sample_mem_writer i_writer (
		.wb_clk (wb_clk),
		.rst_i (rst_i),
		.ctrl_i (ctrl),
		.head_i (head),
		.not_empty_i (not_empty),
		.wbm_req_i (wbm_req_i),
		.pop_o (pop),
		.wbm_rsp_o (wbm_rsp_o),
		.wptr_o (wptr)
	);

	////////////////////////////////////////
	// Control port
	////////////////////////////////////////

	wb_capture_csr i_csr (
		.wb_clk (wb_clk),
		.rst_i (rst_i),
		.wbr_req_i (wbr_req_i),
		.wptr_i (wptr),
		.ovf_cnt_i (ovf_cnt),
		.ovf_seen_i (ovf_seen),
		.level_i (level),
		.wbr_rsp_o (wbr_rsp_o),
		.ctrl_o (ctrl),
		.status_o (status_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_wfd_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wfd_memory;
	import wfd_mem_cfg_pkg::*;
	import wfd_mem_bus_pkg::*;

	// Cycles the tests need, then a factor of two as margin
	localparam int TEST_CYCLES = 8 + 40 * 4 + 80 + 20 + 100 + 2 * 100 + 2 * 100;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic wb_clk;
	logic rst;
	wb_req_t wbm_req;
	wb_req_t wbr_req;
	wb_rsp_t wbm_rsp;
	wb_rsp_t wbr_rsp;
	sample_t gtp_dat;
	logic gtp_vld;
	word_t status;
	capture_status_t status_fields;

	integer seed;
	int cycle_cnt;
	int mismatch_cnt;
	int fail_cnt;

	// Samples driven in the current burst
	sample_t sent[$];
	// Expected content, one entry per beat address
	sample_t accepted[$];

	wfd_memory i_wfd_memory (
		.wb_clk (wb_clk),
		.rst_i (rst),
		.wbm_req_i (wbm_req),
		.wbr_req_i (wbr_req),
		.gtp_dat_i (gtp_dat),
		.gtp_vld_i (gtp_vld),
		.wbm_rsp_o (wbm_rsp),
		.wbr_rsp_o (wbr_rsp),
		.status_o (status)
	);

	// Status word split into its fields
	assign status_fields = capture_status_t'(status[$bits(capture_status_t)-1:0]);

	////////////////////////////////////////
	// Clock and run limit
	////////////////////////////////////////

	initial begin
		wb_clk = 1'b0;
		forever #2 wb_clk = ~wb_clk;
	end

	always @(posedge wb_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	////////////////////////////////////////
	// Reference model and compares
	////////////////////////////////////////

	// Low half at even addresses, high half at odd
	function automatic word_t model_word(input sample_t list[$], input mem_addr_t addr);
		int beat;
		sample_t s;
		beat = int'(addr >> 1);
		if (beat >= list.size()) begin
			return '0;
		end
		s = list[beat];
		return addr[0] ? s[SAMPLE_W-1:WORD_W] : s[WORD_W-1:0];
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_ptr(input string name, input beat_ptr_t got, input beat_ptr_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_ovf(input string name, input ovf_cnt_t got, input ovf_cnt_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	////////////////////////////////////////
	// Bus and stream drivers
	////////////////////////////////////////

	// Entered 1 ns after an edge, left 1 ns after the ack edge
	task automatic wb_write(input logic mem_port, input logic [28:0] addr, input word_t dat);
		wb_req_t req;
		logic ack;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = 1'b1;
		req.addr = addr;
		req.dat = dat;
		if (mem_port) begin
			wbm_req = req;
		end else begin
			wbr_req = req;
		end
		@(posedge wb_clk);
		#1;
		wbm_req = '0;
		wbr_req = '0;
		ack = mem_port ? wbm_rsp.ack : wbr_rsp.ack;
		if (ack !== 1'b1) begin
			fail_cnt++;
			$display("Write to 0x%h was not acked one cycle after the request", addr);
		end
	endtask

	task automatic wb_read(input logic mem_port, input logic [28:0] addr, output word_t dat);
		wb_req_t req;
		logic ack;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.addr = addr;
		if (mem_port) begin
			wbm_req = req;
		end else begin
			wbr_req = req;
		end
		@(posedge wb_clk);
		#1;
		wbm_req = '0;
		wbr_req = '0;
		ack = mem_port ? wbm_rsp.ack : wbr_rsp.ack;
		dat = mem_port ? wbm_rsp.dat : wbr_rsp.dat;
		if (ack !== 1'b1) begin
			fail_cnt++;
			$display("Read of 0x%h was not acked one cycle after the request", addr);
		end
	endtask

	// One valid cycle every gap cycles
	task automatic stream_beats(input int count, input int gap);
		sample_t s;
		for (int i = 0; i < count; i++) begin
			s = {$random(seed), $random(seed)};
			gtp_dat = s;
			gtp_vld = 1'b1;
			sent.push_back(s);
			@(posedge wb_clk);
			#1;
			gtp_vld = 1'b0;
			repeat (gap - 1) begin
				@(posedge wb_clk);
				#1;
			end
		end
	endtask

	task automatic wait_wptr(input beat_ptr_t target, input int bound, input string what);
		int n;
		n = 0;
		while (status_fields.beats_written != target && n < bound) begin
			@(posedge wb_clk);
			#1;
			n++;
		end
		if (status_fields.beats_written != target) begin
			fail_cnt++;
			$display("Write pointer never reached %0d while waiting for %s", target, what);
		end
	endtask

	// FIFO empty means the last pop and pointer step are done
	task automatic wait_drained(input int bound);
		int n;
		n = 0;
		while (status_fields.fifo_level != '0 && n < bound) begin
			@(posedge wb_clk);
			#1;
			n++;
		end
		if (status_fields.fifo_level != '0) begin
			fail_cnt++;
			$display("FIFO did not drain after the sustained burst");
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		word_t d;
		word_t lo;
		word_t hi;
		sample_t beat;
		int pos;
		int found;
		int wptr_start;
		int wptr_end;
		int ovf_start;

		seed = 82192;
		cycle_cnt = 0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		rst = 1'b1;
		wbm_req = '0;
		wbr_req = '0;
		gtp_dat = '0;
		gtp_vld = 1'b0;
		repeat (8) @(posedge wb_clk);
		#1;
		rst = 1'b0;

		// Idle state after reset
		check_word("wbm_ack", word_t'(wbm_rsp.ack), '0);
		check_word("wbr_ack", word_t'(wbr_rsp.ack), '0);
		check_word("wbm_stall", word_t'(wbm_rsp.stall), '0);
		check_word("wbr_stall", word_t'(wbr_rsp.stall), '0);
		check_word("status_o", status, '0);
		wb_read(1'b0, 29'(REG_WPTR), d);
		check_ptr("REG_WPTR", beat_ptr_t'(d), '0);
		wb_read(1'b0, 29'(REG_OVF), d);
		check_ovf("REG_OVF", ovf_cnt_t'(d), '0);

		// Spaced stream, writer keeps up
		wb_write(1'b0, 29'(REG_CTRL), 32'h1);
		stream_beats(40, 4);
		foreach (sent[i]) begin
			accepted.push_back(sent[i]);
		end
		sent.delete();
		wait_wptr(beat_ptr_t'(40), 50, "the spaced stream");
		wb_read(1'b0, 29'(REG_OVF), d);
		check_ovf("REG_OVF", ovf_cnt_t'(d), '0);

		// Back-to-back reads, ack each cycle
		for (int k = 0; k < 80; k++) begin
			wbm_req = '0;
			wbm_req.cyc = 1'b1;
			wbm_req.stb = 1'b1;
			wbm_req.addr = 29'(k);
			@(posedge wb_clk);
			#1;
			if (wbm_rsp.ack !== 1'b1) begin
				fail_cnt++;
				$display("Pipelined read of word %0d was not acked one cycle later", k);
			end
			check_word($sformatf("wbm_dat word %0d", k), wbm_rsp.dat,
				model_word(accepted, mem_addr_t'(k)));
		end
		wbm_req = '0;

		// Disabled capture ignores the stream
		wb_write(1'b0, 29'(REG_CTRL), 32'h0);
		stream_beats(20, 1);
		sent.delete();
		repeat (4) @(posedge wb_clk);
		#1;
		wb_read(1'b0, 29'(REG_WPTR), d);
		check_ptr("REG_WPTR", beat_ptr_t'(d), beat_ptr_t'(40));
		wb_read(1'b0, 29'(REG_OVF), d);
		check_ovf("REG_OVF", ovf_cnt_t'(d), '0);

		// Sustained burst, twice the drain rate
		wb_write(1'b0, 29'(REG_CTRL), 32'h1);
		wb_read(1'b0, 29'(REG_WPTR), d);
		wptr_start = int'(beat_ptr_t'(d));
		wb_read(1'b0, 29'(REG_OVF), d);
		ovf_start = int'(ovf_cnt_t'(d));
		stream_beats(100, 1);
		repeat (2) @(posedge wb_clk);
		#1;
		wait_drained(100);
		wb_read(1'b0, 29'(REG_WPTR), d);
		wptr_end = int'(beat_ptr_t'(d));
		wb_read(1'b0, 29'(REG_OVF), d);
		check_ovf("REG_OVF plus stored beats", ovf_cnt_t'(int'(d) - ovf_start
			+ wptr_end - wptr_start), ovf_cnt_t'(100));
		check_word("status_o.overflow_seen",
			word_t'(status_fields.overflow_seen), 32'h1);

		// Stored beats must be the sent samples in order, gaps allowed
		pos = 0;
		for (int b = wptr_start; b < wptr_end; b++) begin
			wb_read(1'b1, 29'(2 * b), lo);
			wb_read(1'b1, 29'(2 * b + 1), hi);
			beat = {hi, lo};
			found = -1;
			for (int j = pos; j < sent.size() && found < 0; j++) begin
				if (sent[j] == beat) begin
					found = j;
				end
			end
			if (found < 0) begin
				fail_cnt++;
				$display("Stored beat %0d is not among the later sent samples", b);
				accepted.push_back(beat);
			end else begin
				accepted.push_back(sent[found]);
				pos = found + 1;
			end
		end
		sent.delete();

		// Clear, then a wbm write that must not land
		wb_write(1'b0, 29'(REG_CTRL), 32'h2);
		@(posedge wb_clk);
		#1;
		wb_read(1'b0, 29'(REG_WPTR), d);
		check_ptr("REG_WPTR", beat_ptr_t'(d), '0);
		wb_read(1'b0, 29'(REG_OVF), d);
		check_ovf("REG_OVF", ovf_cnt_t'(d), '0);
		check_word("status_o.overflow_seen",
			word_t'(status_fields.overflow_seen), '0);
		wb_write(1'b1, 29'd5, 32'hdead_beef);
		wb_read(1'b1, 29'd5, d);
		check_word("wbm_dat word 5", d, model_word(accepted, mem_addr_t'(5)));

		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wfd_memory.f ====
rtl/wfd_mem_cfg_pkg.sv
rtl/wfd_mem_bus_pkg.sv
rtl/gtp_stream_packer.sv
rtl/beat_fifo.sv
rtl/sample_mem_writer.sv
rtl/wb_capture_csr.sv
rtl/wfd_memory.sv
testbench/tb_wfd_memory.sv

// ==== Bender.yml ====
package:
  name: wfd_memory

sources:
  # Packages first, the RTL depends on both
  - rtl/wfd_mem_cfg_pkg.sv
  - rtl/wfd_mem_bus_pkg.sv
  - rtl/gtp_stream_packer.sv
  - rtl/beat_fifo.sv
  - rtl/sample_mem_writer.sv
  - rtl/wb_capture_csr.sv
  - rtl/wfd_memory.sv
  - target: test
    files:
      - testbench/tb_wfd_memory.sv
